/* flist.f */
+incdir+tb
rtl/nnWeightsPkg.sv
rtl/nnCtrlPkg.sv
rtl/neuronNode.sv
rtl/featureLoader.sv
rtl/inferenceSequencer.sv
rtl/mlpClassifier.sv
tb/mlpClassifierTb.sv

/* rtl/featureLoader.sv */
`timescale 1ns/10ps
`default_nettype none

module featureLoader (
	input wire logic clk,
	input wire logic reset,
	input wire logic sampleValid,
	input wire logic signed [7:0] sampleData,
	output logic [nnWeightsPkg::NumFeatures-1:0][7:0] frameFeatures,
	output logic frameReady
);

	localparam int LastSample = nnWeightsPkg::NumFeatures - 1;

	logic [nnWeightsPkg::NumFeatures-1:0][7:0] sampleBuf;
	logic [nnWeightsPkg::NumFeatures-1:0][7:0] shifted;
	logic [3:0] sampleCnt;
	logic lastSample;

	// new sample enters at the top, sample 0 drifts down to slot 0.
	assign shifted = {sampleData, sampleBuf[nnWeightsPkg::NumFeatures-1:1]};
	assign lastSample = (sampleCnt == 4'(LastSample));

	always_ff @(posedge clk)
	begin
		if (sampleValid)
		begin
			sampleBuf <= shifted;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sampleCnt <= '0; // partial frame is dropped.
			frameReady <= 1'b0;
			frameFeatures <= '0;
		end
		else
		begin
			frameReady <= 1'b0;
			if (sampleValid)
			begin
				if (lastSample)
				begin
					sampleCnt <= '0;
					frameFeatures <= shifted;
					frameReady <= 1'b1;
				end
				else
				begin
					sampleCnt <= sampleCnt + 4'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/inferenceSequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module inferenceSequencer (
	input wire logic clk,
	input wire logic reset,
	input wire logic frameReady,
	input wire logic [nnWeightsPkg::NumClasses-1:0][7:0] classActs,
	output logic resultValid,
	output logic [nnCtrlPkg::ClassWidth-1:0] classId,
	output logic [7:0] score
);

	// frameReady lands on the hidden input edge, so one edge is already spent.
	localparam int HiddenWait = nnCtrlPkg::NodeLatency - 2;
	// output layer, leaving one edge for the resolve step.
	localparam int OutputWait = nnCtrlPkg::ResultLatency - nnCtrlPkg::NodeLatency - 2;

	nnCtrlPkg::seqState state;
	logic [2:0] waitCnt;
	logic [nnCtrlPkg::ClassWidth-1:0] bestIdx;
	logic [7:0] bestAct;

	// argmax, strict compare keeps the lowest index on ties.
	always_comb
	begin
		bestIdx = '0;
		bestAct = classActs[0];
		for (int i = 1; i < nnWeightsPkg::NumClasses; i++)
		begin
			if (classActs[i] > bestAct)
			begin
				bestIdx = i[nnCtrlPkg::ClassWidth-1:0];
				bestAct = classActs[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nnCtrlPkg::SeqIdle;
			waitCnt <= '0;
			resultValid <= 1'b0;
			classId <= '0;
			score <= '0;
		end
		else
		begin
			resultValid <= 1'b0;
			if (frameReady)
			begin
				// a new frame always restarts the count.
				state <= nnCtrlPkg::SeqHidden;
				waitCnt <= 3'(HiddenWait);
			end
			else
			begin
				case (state)
					nnCtrlPkg::SeqHidden:
					begin
						if (waitCnt == '0)
						begin
							state <= nnCtrlPkg::SeqOutput;
							waitCnt <= 3'(OutputWait);
						end
						else
							waitCnt <= waitCnt - 3'd1;
					end
					nnCtrlPkg::SeqOutput:
					begin
						if (waitCnt == '0)
							state <= nnCtrlPkg::SeqResolve;
						else
							waitCnt <= waitCnt - 3'd1;
					end
					nnCtrlPkg::SeqResolve:
					begin
						classId <= bestIdx;
						score <= bestAct;
						resultValid <= 1'b1;
						state <= nnCtrlPkg::SeqIdle;
					end
					default:
						state <= nnCtrlPkg::SeqIdle;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/mlpClassifier.sv */
`timescale 1ns/10ps
`default_nettype none

module mlpClassifier (
	input wire logic clk,
	input wire logic reset,
	input wire logic sampleValid,
	input wire logic signed [7:0] sampleData,
	output logic resultValid,
	output logic [nnCtrlPkg::ClassWidth-1:0] classId,
	output logic [7:0] score
);

	logic [nnWeightsPkg::NumFeatures-1:0][7:0] frameFeatures;
	logic frameReady;
	logic [nnWeightsPkg::NumHidden-1:0][7:0] hiddenActs;
	logic [nnWeightsPkg::NumClasses-1:0][7:0] classActs;

	featureLoader featureLoader_inst (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.frameFeatures(frameFeatures),
		.frameReady(frameReady)
	);

	// hidden layer.
	neuronNode #(
		.NumInputs(nnWeightsPkg::NumFeatures),
		.Weights(nnWeightsPkg::HiddenWeights[0]),
		.Bias(nnWeightsPkg::HiddenBias[0])
	) hidden0_inst (
		.clk(clk), .reset(reset), .nodeInputs(frameFeatures), .activation(hiddenActs[0])
	);

	neuronNode #(
		.NumInputs(nnWeightsPkg::NumFeatures),
		.Weights(nnWeightsPkg::HiddenWeights[1]),
		.Bias(nnWeightsPkg::HiddenBias[1])
	) hidden1_inst (
		.clk(clk), .reset(reset), .nodeInputs(frameFeatures), .activation(hiddenActs[1])
	);

	neuronNode #(
		.NumInputs(nnWeightsPkg::NumFeatures),
		.Weights(nnWeightsPkg::HiddenWeights[2]),
		.Bias(nnWeightsPkg::HiddenBias[2])
	) hidden2_inst (
		.clk(clk), .reset(reset), .nodeInputs(frameFeatures), .activation(hiddenActs[2])
	);

	neuronNode #(
		.NumInputs(nnWeightsPkg::NumFeatures),
		.Weights(nnWeightsPkg::HiddenWeights[3]),
		.Bias(nnWeightsPkg::HiddenBias[3])
	) hidden3_inst (
		.clk(clk), .reset(reset), .nodeInputs(frameFeatures), .activation(hiddenActs[3])
	);

	// output layer, one neuron per class.
	neuronNode #(
		.NumInputs(nnWeightsPkg::NumHidden),
		.Weights(nnWeightsPkg::OutputWeights[0]),
		.Bias(nnWeightsPkg::OutputBias[0])
	) class0_inst (
		.clk(clk), .reset(reset), .nodeInputs(hiddenActs), .activation(classActs[0])
	);

	neuronNode #(
		.NumInputs(nnWeightsPkg::NumHidden),
		.Weights(nnWeightsPkg::OutputWeights[1]),
		.Bias(nnWeightsPkg::OutputBias[1])
	) class1_inst (
		.clk(clk), .reset(reset), .nodeInputs(hiddenActs), .activation(classActs[1])
	);

	neuronNode #(
		.NumInputs(nnWeightsPkg::NumHidden),
		.Weights(nnWeightsPkg::OutputWeights[2]),
		.Bias(nnWeightsPkg::OutputBias[2])
	) class2_inst (
		.clk(clk), .reset(reset), .nodeInputs(hiddenActs), .activation(classActs[2])
	);

	inferenceSequencer inferenceSequencer_inst (
		.clk(clk),
		.reset(reset),
		.frameReady(frameReady),
		.classActs(classActs),
		.resultValid(resultValid),
		.classId(classId),
		.score(score)
	);

endmodule

`default_nettype wire

/* rtl/neuronNode.sv */
`timescale 1ns/10ps
`default_nettype none

module neuronNode #(
	parameter int NumInputs = 15,
	parameter logic [0:NumInputs-1][7:0] Weights = '0,
	parameter logic [15:0] Bias = '0
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic [NumInputs-1:0][7:0] nodeInputs,
	output logic [7:0] activation
);

	logic signed [7:0] inReg [NumInputs];
	logic signed [15:0] prod [NumInputs];
	logic signed [22:0] sumNext;
	logic signed [22:0] sumReg;
	logic [8:0] rounded;

	always_comb
	begin
		for (int i = 0; i < NumInputs; i++)
		begin
			prod[i] = inReg[i] * $signed(Weights[i]);
		end
	end

	// every term sign-extended to 23 bits.
	always_comb
	begin
		sumNext = $signed(Bias);
		for (int i = 0; i < NumInputs; i++)
		begin
			sumNext = sumNext + prod[i];
		end
	end

	assign rounded = {1'b0, sumReg[13:6]} + {8'd0, sumReg[5]};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NumInputs; i++)
			begin
				inReg[i] <= '0;
			end
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			for (int i = 0; i < NumInputs; i++)
			begin
				inReg[i] <= $signed(nodeInputs[i]);
			end
			sumReg <= sumNext;

			if (sumReg[22])
			begin
				activation <= '0; // negative clamps to zero.
			end
			else if (|sumReg[21:13])
			begin
				activation <= 8'(nnWeightsPkg::ActMax);
			end
			else if (rounded > 9'(nnWeightsPkg::ActMax))
			begin
				// rounding up from 127.5 and above.
				activation <= 8'(nnWeightsPkg::ActMax);
			end
			else
			begin
				activation <= rounded[7:0];
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/nnCtrlPkg.sv */
`default_nettype none

package nnCtrlPkg;

	typedef enum logic [1:0]
	{
		SeqIdle,
		SeqHidden,
		SeqOutput,
		SeqResolve
	} seqState;

	// inputs in, sum, activation out.
	localparam int NodeLatency = 3;

	localparam int ClassWidth = 2;

	// accepting edge of the last sample to resultValid rising.
	localparam int ResultLatency = 7;

endpackage

`default_nettype wire

/* rtl/nnWeightsPkg.sv */
`default_nettype none

package nnWeightsPkg;

	localparam int NumFeatures = 15;
	localparam int NumHidden = 4;
	localparam int NumClasses = 3;

	// activation ceiling.
	localparam int ActMax = 127;

	// one row per hidden neuron, element 0 is the first in each row.
	localparam logic [0:NumHidden-1][0:NumFeatures-1][7:0] HiddenWeights = '{
		'{
			8'sd12, -8'sd5, 8'sd20, 8'sd3, -8'sd14,
			8'sd27, -8'sd8, 8'sd6, -8'sd19, 8'sd11,
			8'sd25, -8'sd2, 8'sd9, -8'sd30, 8'sd4
		},
		'{
			-8'sd22, 8'sd15, -8'sd7, 8'sd18, 8'sd29,
			-8'sd11, 8'sd2, -8'sd26, 8'sd13, -8'sd4,
			-8'sd17, 8'sd21, -8'sd9, 8'sd8, 8'sd30
		},
		'{
			8'sd5, 8'sd28, -8'sd13, -8'sd24, 8'sd7,
			8'sd16, -8'sd31, 8'sd10, 8'sd1, 8'sd23,
			-8'sd6, -8'sd15, 8'sd26, -8'sd3, -8'sd20
		},
		'{
			-8'sd18, -8'sd9, 8'sd24, 8'sd11, -8'sd2,
			-8'sd27, 8'sd19, 8'sd14, -8'sd12, -8'sd25,
			8'sd3, 8'sd17, -8'sd8, 8'sd22, 8'sd6
		}
	};

	localparam logic [0:NumHidden-1][15:0] HiddenBias = '{
		16'sd64,
		-16'sd128,
		16'sd0,
		-16'sd32
	};

	// one row per class, indexed by hidden neuron.
	localparam logic [0:NumClasses-1][0:NumHidden-1][7:0] OutputWeights = '{
		'{8'sd25, -8'sd12, 8'sd18, -8'sd6},
		'{-8'sd9, 8'sd27, -8'sd14, 8'sd20},
		'{8'sd14, 8'sd8, -8'sd21, 8'sd29}
	};

	// negative so an idle hidden layer leaves every class at 0.
	localparam logic [0:NumClasses-1][15:0] OutputBias = '{
		-16'sd200,
		-16'sd150,
		-16'sd96
	};

endpackage

`default_nettype wire

/* tb/mlpModel.svh */
`ifndef MLP_MODEL_SVH
`define MLP_MODEL_SVH

// 32-bit xorshift step.
function automatic logic [31:0] xorshiftNext(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	y = y ^ (y << 5);
	return y;
endfunction

// activation of one neuron from its full signed sum.
function automatic logic [7:0] refActivation(input int sum);
	int rounded;
	if (sum < 0)
		return 8'd0;
	if (sum >= (1 << 13))
		return 8'(nnWeightsPkg::ActMax); // anything in bits 21..13.
	rounded = (sum >> 6) + ((sum >> 5) & 1);
	if (rounded > nnWeightsPkg::ActMax)
		return 8'(nnWeightsPkg::ActMax);
	return 8'(rounded);
endfunction

function automatic logic [nnWeightsPkg::NumHidden-1:0][7:0] hiddenActivations(
	input logic [nnWeightsPkg::NumFeatures-1:0][7:0] feats);
	logic [nnWeightsPkg::NumHidden-1:0][7:0] acts;
	int sum;
	for (int h = 0; h < nnWeightsPkg::NumHidden; h++)
	begin
		sum = int'($signed(nnWeightsPkg::HiddenBias[h]));
		for (int i = 0; i < nnWeightsPkg::NumFeatures; i++)
		begin
			sum += int'($signed(feats[i])) * int'($signed(nnWeightsPkg::HiddenWeights[h][i]));
		end
		acts[h] = refActivation(sum);
	end
	return acts;
endfunction

function automatic logic [nnWeightsPkg::NumClasses-1:0][7:0] classActivations(
	input logic [nnWeightsPkg::NumFeatures-1:0][7:0] feats);
	logic [nnWeightsPkg::NumHidden-1:0][7:0] hid;
	logic [nnWeightsPkg::NumClasses-1:0][7:0] acts;
	int sum;
	hid = hiddenActivations(feats);
	for (int c = 0; c < nnWeightsPkg::NumClasses; c++)
	begin
		sum = int'($signed(nnWeightsPkg::OutputBias[c]));
		for (int h = 0; h < nnWeightsPkg::NumHidden; h++)
		begin
			sum += int'($signed(hid[h])) * int'($signed(nnWeightsPkg::OutputWeights[c][h]));
		end
		acts[c] = refActivation(sum);
	end
	return acts;
endfunction

// lowest index wins a tie.
function automatic logic [nnCtrlPkg::ClassWidth-1:0] argmaxClass(
	input logic [nnWeightsPkg::NumClasses-1:0][7:0] acts);
	int best;
	best = 0;
	for (int c = 1; c < nnWeightsPkg::NumClasses; c++)
	begin
		if (acts[c] > acts[best])
			best = c;
	end
	return best[nnCtrlPkg::ClassWidth-1:0];
endfunction

`endif

/* tb/mlpClassifierTb.sv */
`timescale 1ns/10ps
`default_nettype none

module mlpClassifierTb;

	localparam int WaitLimit = 200;

	logic clk;
	logic reset;
	logic sampleValid;
	logic signed [7:0] sampleData;
	logic resultValid;
	logic [nnCtrlPkg::ClassWidth-1:0] classId;
	logic [7:0] score;

	logic [31:0] rngState;
	logic [nnWeightsPkg::NumFeatures-1:0][7:0] frameBuf = '0;
	int sampleIdx = 0;
	int framesDone = 0;
	int resultCount = 0;
	logic [nnCtrlPkg::ResultLatency:0] latencyPipe;
	logic [nnCtrlPkg::ClassWidth-1:0] expClassId;
	logic [7:0] expScore;
	logic [nnCtrlPkg::ClassWidth+7:0] expQ [$]; // {classId, score} per frame.

	`include "mlpModel.svh"

	mlpClassifier mlpClassifier_inst (
		.clk(clk),
		.reset(reset),
		.sampleValid(sampleValid),
		.sampleData(sampleData),
		.resultValid(resultValid),
		.classId(classId),
		.score(score)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#4 clk = ~clk;
	end

	task automatic reportMismatch(input string sigName, input logic [31:0] got,
		input logic [31:0] want);
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", sigName, got, want);
		$display("Test failed");
		$fatal(1, "mismatch on %s", sigName);
	endtask

	task automatic reportTimeout(input string what);
		nnCtrlPkg::seqState state;
		state = mlpClassifier_inst.inferenceSequencer_inst.state;
		$display("timed out waiting for %s, sequencer in %s", what, state.name());
		$display("Test failed");
		$fatal(1, "timeout");
	endtask

	function automatic logic [31:0] nextRandom();
		rngState = xorshiftNext(rngState);
		return rngState;
	endfunction

	function automatic logic [nnWeightsPkg::NumFeatures-1:0][7:0] randomFrame();
		logic [nnWeightsPkg::NumFeatures-1:0][7:0] f;
		for (int i = 0; i < nnWeightsPkg::NumFeatures; i++)
			f[i] = 8'(nextRandom());
		return f;
	endfunction

	// full-scale samples signed to push one class up through both layers.
	function automatic logic [nnWeightsPkg::NumFeatures-1:0][7:0] extremeFrame(input int cls);
		logic [nnWeightsPkg::NumFeatures-1:0][7:0] f;
		int pull;
		for (int i = 0; i < nnWeightsPkg::NumFeatures; i++)
		begin
			pull = 0;
			for (int h = 0; h < nnWeightsPkg::NumHidden; h++)
			begin
				pull += int'($signed(nnWeightsPkg::OutputWeights[cls][h]))
					* int'($signed(nnWeightsPkg::HiddenWeights[h][i]));
			end
			f[i] = (pull >= 0) ? 8'h7f : 8'h80;
		end
		return f;
	endfunction

	task automatic findTieFrame(output logic [nnWeightsPkg::NumFeatures-1:0][7:0] frame);
		logic [nnWeightsPkg::NumClasses-1:0][7:0] acts;
		logic [nnCtrlPkg::ClassWidth-1:0] top;
		int ties;
		for (int t = 0; t < 4000; t++)
		begin
			frame = randomFrame();
			acts = classActivations(frame);
			top = argmaxClass(acts);
			ties = 0;
			for (int c = 0; c < nnWeightsPkg::NumClasses; c++)
			begin
				if (acts[c] == acts[top])
					ties++;
			end
			if (ties > 1 && acts[top] != 8'd0)
				return;
		end
		$display("no frame with two equal nonzero top activations was found");
		$display("Test failed");
		$fatal(1, "tie search exhausted");
	endtask

	task automatic sendSamples(input logic [nnWeightsPkg::NumFeatures-1:0][7:0] feats,
		input int count, input int maxGap);
		int gap;
		for (int i = 0; i < count; i++)
		begin
			gap = (maxGap > 0) ? int'(nextRandom() % (maxGap + 1)) : 0;
			for (int g = 0; g < gap; g++)
			begin
				@(posedge clk);
				#1;
				sampleValid = 1'b0;
			end
			@(posedge clk);
			#1;
			sampleValid = 1'b1;
			sampleData = feats[i];
		end
	endtask

	task automatic releaseStrobe();
		@(posedge clk);
		#1;
		sampleValid = 1'b0;
		sampleData = '0;
	endtask

	task automatic waitForResults(input int target);
		int cycles;
		cycles = 0;
		while (resultCount < target)
		begin
			@(posedge clk);
			#1;
			cycles++;
			if (cycles > WaitLimit)
				reportTimeout("resultValid");
		end
	endtask

	// mirrors the frame stream and queues the model's answer per frame.
	always @(posedge clk)
	begin : trackFrames
		logic [nnWeightsPkg::NumClasses-1:0][7:0] acts;
		logic [nnCtrlPkg::ClassWidth-1:0] cls;
		logic [nnCtrlPkg::ClassWidth+7:0] head;
		if (reset)
		begin
			sampleIdx <= 0;
			latencyPipe <= '0;
			expClassId <= '0;
			expScore <= '0;
			expQ.delete();
		end
		else
		begin
			latencyPipe <= {latencyPipe[nnCtrlPkg::ResultLatency-1:0],
				sampleValid && (sampleIdx == nnWeightsPkg::NumFeatures - 1)};
			if (sampleValid)
			begin
				frameBuf[sampleIdx] = sampleData;
				if (sampleIdx == nnWeightsPkg::NumFeatures - 1)
				begin
					sampleIdx <= 0;
					acts = classActivations(frameBuf);
					cls = argmaxClass(acts);
					expQ.push_back({cls, acts[cls]});
					framesDone <= framesDone + 1;
				end
				else
					sampleIdx <= sampleIdx + 1;
			end
			if (latencyPipe[nnCtrlPkg::ResultLatency-1] && expQ.size() > 0)
			begin
				head = expQ.pop_front(); // lands with the DUT's own update.
				expClassId <= head[nnCtrlPkg::ClassWidth+7:8];
				expScore <= head[7:0];
			end
			if (resultValid)
				resultCount <= resultCount + 1;
		end
	end

	resultTiming: assert property (@(posedge clk) disable iff (reset)
		resultValid == latencyPipe[nnCtrlPkg::ResultLatency])
	else
		reportMismatch("resultValid", $sampled(resultValid),
			$sampled(latencyPipe[nnCtrlPkg::ResultLatency]));

	classMatch: assert property (@(posedge clk) disable iff (reset) classId == expClassId)
	else
		reportMismatch("classId", $sampled(classId), $sampled(expClassId));

	scoreMatch: assert property (@(posedge clk) disable iff (reset) score == expScore)
	else
		reportMismatch("score", $sampled(score), $sampled(expScore));

	initial
	begin
		logic [nnWeightsPkg::NumFeatures-1:0][7:0] frame;
		rngState = 32'd16;
		reset = 1'b1;
		sampleValid = 1'b0;
		sampleData = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		repeat (24) @(posedge clk); // idle outputs stay zero.
		#1;

		for (int f = 0; f < 20; f++)
		begin
			sendSamples(randomFrame(), nnWeightsPkg::NumFeatures, 3);
			releaseStrobe();
			waitForResults(framesDone);
		end

		for (int c = 0; c < nnWeightsPkg::NumClasses; c++)
		begin
			sendSamples(extremeFrame(c), nnWeightsPkg::NumFeatures, 0);
			releaseStrobe();
			waitForResults(framesDone);
		end

		// hidden 0 sums to 8168, so rounding would reach 128.
		frame = '0;
		frame[2] = 8'd75;
		frame[5] = 8'd127;
		frame[10] = 8'd127;
		sendSamples(frame, nnWeightsPkg::NumFeatures, 0);
		releaseStrobe();
		waitForResults(framesDone);

		// all-zero frame drives every output sum below zero.
		sendSamples('0, nnWeightsPkg::NumFeatures, 1);
		releaseStrobe();
		waitForResults(framesDone);

		findTieFrame(frame);
		sendSamples(frame, nnWeightsPkg::NumFeatures, 1);
		releaseStrobe();
		waitForResults(framesDone);

		for (int f = 0; f < 4; f++)
			sendSamples(randomFrame(), nnWeightsPkg::NumFeatures, 0);
		releaseStrobe();
		waitForResults(framesDone);

		// partial frame, then reset.
		sendSamples(randomFrame(), 9, 1);
		releaseStrobe();
		reset = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		sendSamples(randomFrame(), nnWeightsPkg::NumFeatures, 2);
		releaseStrobe();
		waitForResults(framesDone);

		repeat (12) @(posedge clk);
		#1;
		if (resultCount == framesDone && expQ.size() == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			$display("%0d results seen for %0d frames", resultCount, framesDone);
			$display("Test failed");
			$fatal(1, "result count mismatch");
		end
	end

endmodule

`default_nettype wire
